/* project.f */
+incdir+.
rob_pkg.sv
dispatch_alloc.sv
rob_thread_bank.sv
commit_select.sv
rob_top.sv
tb_rob.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f project.f --top-module tb_rob -o tb_rob
then
	echo "verilator build failed"
	exit 1
fi

if ! output=$(./obj_dir/tb_rob)
then
	echo "$output"
	echo "simulation exited with an error"
	exit 1
fi
echo "$output"

if echo "$output" | grep -q "^TB PASSED$"
then
	exit 0
fi
exit 1

/* tb_rob.sv */
// testbench for the two-thread reorder buffer
// random dispatch and completion from an LCG, checked every cycle against a queue model
// inputs change 5 ns after the rising edge, outputs are compared on the falling edge
// only ready threads get dispatches and nothing is driven in a flush cycle
`timescale 1ns/1ps
`include "rob_macros.svh"

module tb_rob;
	import rob_pkg::*;

	typedef commit_t [1:0] commit_pair_t;

	logic				clock;
	logic				reset;
	logic				dispatch_thread;
	dispatch_inst_t		inst_a;
	dispatch_inst_t		inst_b;
	completion_t		comp_a;
	completion_t		comp_b;
	rob_tag_t			tag_a;
	rob_tag_t			tag_b;
	logic [1:0]			ready;
	commit_t			commit_a;
	commit_t			commit_b;

	// queue model as it stands after the last clock edge
	rob_entry_t			m_ent [2][`ROB_DEPTH];
	logic				m_valid [2][`ROB_DEPTH];
	rob_ptr_t			m_head [2];
	rob_ptr_t			m_tail [2];
	pc_t				next_pc [2];
	logic [1:0]			after_flush;	// thread waits for its first dispatch after a flush

	commit_t			exp_a;
	commit_t			exp_b;
	rob_tag_t			exp_tag_a;
	rob_tag_t			exp_tag_b;
	logic [1:0]			exp_ready;
	logic				checking;

	int					disp_mode;	// 0 none, 1 thread 1, 2 thread 2, 3 either
	logic				pair_only;
	int unsigned		comp_rate;	// chance per port in eighths
	logic				mis_en;

	logic [31:0]		lcg_state;
	int					failures;
	int					mismatches;
	int					commits_seen;
	int					dual_seen;
	int					flush_count;
	int					post_flush_disp;
	int					tests_run;
	int					tests_failed;
	int					test_start_errors;

	rob_top rob_top_i (
		.clock				(clock),
		.reset				(reset),
		.dispatch_thread	(dispatch_thread),
		.inst_a				(inst_a),
		.inst_b				(inst_b),
		.comp_a				(comp_a),
		.comp_b				(comp_b),
		.tag_a				(tag_a),
		.tag_b				(tag_b),
		.ready				(ready),
		.commit_a			(commit_a),
		.commit_b			(commit_b)
	);

	always #50 clock = ~clock;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int unsigned rand_below(int unsigned n);
		return (lcg_next() >> 8) % n;	// low bits of an LCG repeat too soon
	endfunction

	function automatic logic entry_done(int t, rob_ptr_t ptr);
		return m_valid[t][rob_idx_t'(ptr)] && m_ent[t][rob_idx_t'(ptr)].done;
	endfunction

	function automatic commit_t idle_commit();
		commit_t c;
		c = '0;
		c.arn_dest = arn_t'(`ZERO_REG);
		return c;
	endfunction

	function automatic commit_t entry_commit(int t, rob_ptr_t ptr);
		commit_t c;
		rob_entry_t e;
		e = m_ent[t][rob_idx_t'(ptr)];
		c = '0;
		c.valid = 1'b1;
		c.thread = t[0];
		c.pc = e.pc;
		c.target_pc = e.target_pc;
		c.is_branch = e.is_branch;
		c.mispredict = e.mispredict;
		c.arn_dest = e.arn_dest;
		c.prn_dest = e.prn_dest;
		c.is_halt = e.is_halt;
		return c;
	endfunction

	// reference for one cycle of commits, taken from the model queues
	function automatic commit_pair_t predict_commits();
		commit_pair_t p;
		logic [1:0] head_ok;
		int ta;
		rob_ptr_t nxt;
		p[0] = idle_commit();
		p[1] = idle_commit();
		head_ok[0] = entry_done(0, m_head[0]);
		head_ok[1] = entry_done(1, m_head[1]);
		if (head_ok[0] || head_ok[1])
		begin
			ta = head_ok[0] ? 0 : 1;	// thread 1 first
			p[0] = entry_commit(ta, m_head[ta]);
			nxt = m_head[ta] + rob_ptr_t'(1);
			if (nxt != m_tail[ta] && entry_done(ta, nxt) && !(p[0].is_branch && p[0].mispredict))
				p[1] = entry_commit(ta, nxt);
			else if (ta == 0 && head_ok[1])
				p[1] = entry_commit(1, m_head[1]);
		end
		return p;
	endfunction

	function automatic logic [1:0] expected_ready();
		logic [1:0] r;
		rob_ptr_t used;
		int t;
		for (t = 0; t < 2; t++)
		begin
			used = m_tail[t] - m_head[t];
			r[t] = (`ROB_DEPTH - int'(used)) >= 2;	// room for a pair
		end
		return r;
	endfunction

	function automatic logic queues_empty();
		return (m_head[0] == m_tail[0]) && (m_head[1] == m_tail[1]);
	endfunction

	function automatic dispatch_inst_t new_inst(logic thr);
		dispatch_inst_t d;
		d = '0;
		d.valid = 1'b1;
		d.pc = next_pc[thr];
		d.arn_dest = arn_t'(rand_below(`ARCH_REGS - 1));
		d.prn_dest = prn_t'(rand_below(`PRF_DEPTH));
		d.is_branch = (rand_below(4) == 0);
		d.is_halt = (rand_below(32) == 0);
		next_pc[thr] = next_pc[thr] + pc_t'(4);
		return d;
	endfunction

	// picks a live entry that is not done yet, from either thread
	function automatic completion_t pick_completion();
		completion_t c;
		int first;
		int start;
		int j;
		int k;
		int t;
		rob_idx_t i;
		c = '0;
		if (rand_below(8) >= comp_rate)
			return c;
		first = int'(rand_below(2));
		start = int'(rand_below(`ROB_DEPTH));
		for (j = 0; j < 2; j++)
		begin
			t = first ^ j;
			for (k = 0; k < `ROB_DEPTH; k++)
			begin
				i = rob_idx_t'(start + k);
				if (m_valid[t][i] && !m_ent[t][i].done)
				begin
					c.valid = 1'b1;
					c.tag.thread = t[0];
					c.tag.idx = i;
					c.mispredict = mis_en && m_ent[t][i].is_branch && (rand_below(3) == 0);
					c.target_pc = pc_t'({lcg_next(), lcg_next()});
					return c;
				end
			end
		end
		return c;
	endfunction

	function automatic void print_mismatch(string msg);
		$display("MISMATCH at %0t ns: %s", $time, msg);
	endfunction

	task automatic report_failure(string msg);
		$display("ERROR at %0t ns: %s", $time, msg);
		failures++;
	endtask

	task automatic clear_model();
		int t;
		int i;
		for (t = 0; t < 2; t++)
		begin
			for (i = 0; i < `ROB_DEPTH; i++)
			begin
				m_ent[t][i] = '0;
				m_valid[t][i] = 1'b0;
			end
			m_head[t] = '0;
			m_tail[t] = '0;
		end
		next_pc[0] = pc_t'(64'h0000_0000_0000_1000);
		next_pc[1] = pc_t'(64'h0000_0000_8000_0000);
		after_flush = 2'b00;
	endtask

	task automatic load_entry(logic thr, dispatch_inst_t d);
		rob_idx_t i;
		i = rob_idx_t'(m_tail[thr]);
		m_ent[thr][i] = '0;
		m_ent[thr][i].pc = d.pc;
		m_ent[thr][i].arn_dest = d.arn_dest;
		m_ent[thr][i].prn_dest = d.prn_dest;
		m_ent[thr][i].is_branch = d.is_branch;
		m_ent[thr][i].is_halt = d.is_halt;
		m_valid[thr][i] = 1'b1;
		m_tail[thr] = m_tail[thr] + rob_ptr_t'(1);
	endtask

	task automatic mark_done(completion_t c);
		if (c.valid)
		begin
			m_ent[c.tag.thread][c.tag.idx].done = 1'b1;
			m_ent[c.tag.thread][c.tag.idx].mispredict = c.mispredict;
			m_ent[c.tag.thread][c.tag.idx].target_pc = c.target_pc;
		end
	endtask

	// what the clock edge does to the model
	task automatic update_model(commit_pair_t p, logic [1:0] fl, logic thr, int n,
			dispatch_inst_t ia, dispatch_inst_t ib, completion_t ca, completion_t cb);
		int s;
		int t;
		int i;
		for (s = 0; s < 2; s++)
		begin
			if (p[s].valid)
			begin
				t = p[s].thread ? 1 : 0;
				m_valid[t][rob_idx_t'(m_head[t])] = 1'b0;
				m_head[t] = m_head[t] + rob_ptr_t'(1);
			end
		end
		for (t = 0; t < 2; t++)
		begin
			if (fl[t])
			begin
				for (i = 0; i < `ROB_DEPTH; i++)
					m_valid[t][i] = 1'b0;
				m_tail[t] = m_head[t];	// back to just after the branch
			end
		end
		if (n > 0)
			load_entry(thr, ia);
		if (n > 1)
			load_entry(thr, ib);
		mark_done(cb);
		mark_done(ca);	// port a wins on the same entry
	endtask

	task automatic drive_cycle();
		commit_pair_t p;
		logic [1:0] fl;
		logic thr;
		int n;
		int s;
		dispatch_inst_t ia;
		dispatch_inst_t ib;
		completion_t ca;
		completion_t cb;
		p = predict_commits();
		fl = 2'b00;
		for (s = 0; s < 2; s++)
		begin
			if (p[s].valid && p[s].is_branch && p[s].mispredict)
				fl[p[s].thread] = 1'b1;
		end
		exp_ready = expected_ready();
		ia = '0;
		ib = '0;
		ca = '0;
		cb = '0;
		n = 0;
		thr = (disp_mode == 2) || (disp_mode == 3 && rand_below(2) == 1);
		if (fl != 2'b00)
			after_flush = after_flush | fl;
		else
		begin
			if (disp_mode != 0 && exp_ready[thr] && (pair_only || rand_below(4) != 0))
				n = (pair_only || rand_below(2) == 1) ? 2 : 1;
			if (n > 0)
				ia = new_inst(thr);
			if (n > 1)
				ib = new_inst(thr);
			ca = pick_completion();
			cb = pick_completion();
		end
		exp_tag_a = '0;
		exp_tag_b = '0;
		if (n > 0)
		begin
			exp_tag_a.thread = thr;
			exp_tag_a.idx = rob_idx_t'(m_tail[thr]);
			if (after_flush[thr])
			begin
				post_flush_disp++;
				after_flush[thr] = 1'b0;
			end
		end
		if (n > 1)
		begin
			exp_tag_b.thread = thr;
			exp_tag_b.idx = rob_idx_t'(m_tail[thr]) + rob_idx_t'(1);
		end
		exp_a = p[0];
		exp_b = p[1];
		dispatch_thread = thr;
		inst_a = ia;
		inst_b = ib;
		comp_a = ca;
		comp_b = cb;
		update_model(p, fl, thr, n, ia, ib, ca, cb);
	endtask

	task automatic step();
		drive_cycle();
		@(posedge clock);
		#5;
	endtask

	task automatic run_cycles(int n);
		repeat (n) step();
	endtask

	task automatic drain_queues();
		int k;
		disp_mode = 0;
		comp_rate = 8;
		mis_en = 1'b0;
		k = 0;
		while (!queues_empty() && k < 100)
		begin
			step();
			k++;
		end
		if (!queues_empty())
			report_failure("timeout, the queues did not drain within 100 cycles");
	endtask

	task automatic check_first_tags(logic thr);
		drive_cycle();
		@(negedge clock);
		if (tag_a.thread !== thr || tag_b.thread !== thr || tag_a.idx !== rob_idx_t'(0)
				|| tag_b.idx !== rob_idx_t'(1))
		begin
			print_mismatch($sformatf(
				"first tags of thread bit %0b are %0d and %0d, expected 0 and 1",
				thr, tag_a.idx, tag_b.idx));
			failures++;
		end
		if (commit_a.valid !== 1'b0 || commit_b.valid !== 1'b0)
		begin
			print_mismatch("commit valid seen right after reset");
			failures++;
		end
		@(posedge clock);
		#5;
	endtask

	task automatic finish_test(string name);
		int errs;
		errs = failures + mismatches - test_start_errors;
		tests_run++;
		if (errs == 0)
			$display("test %s: ok", name);
		else
		begin
			tests_failed++;
			$display("test %s: %0d errors", name, errs);
		end
		test_start_errors = failures + mismatches;
	endtask

	always @(negedge clock)
	begin
		if (checking)
		begin
			if (commit_a !== exp_a)
			begin
				print_mismatch($sformatf(
					"commit_a valid %0b thread %0b pc %h, expected %0b %0b %h",
					commit_a.valid, commit_a.thread, commit_a.pc,
					exp_a.valid, exp_a.thread, exp_a.pc));
				mismatches++;
			end
			if (commit_b !== exp_b)
			begin
				print_mismatch($sformatf(
					"commit_b valid %0b thread %0b pc %h, expected %0b %0b %h",
					commit_b.valid, commit_b.thread, commit_b.pc,
					exp_b.valid, exp_b.thread, exp_b.pc));
				mismatches++;
			end
			if (tag_a !== exp_tag_a || tag_b !== exp_tag_b)
			begin
				print_mismatch($sformatf("tags %h %h, expected %h %h",
					tag_a, tag_b, exp_tag_a, exp_tag_b));
				mismatches++;
			end
			if (ready !== exp_ready)
			begin
				print_mismatch($sformatf("ready %b, expected %b", ready, exp_ready));
				mismatches++;
			end
			if (commit_a.valid)
				commits_seen++;
			if (commit_b.valid)
				commits_seen++;
			if (commit_a.valid && commit_b.valid && commit_a.thread != commit_b.thread)
				dual_seen++;
			if (commit_a.valid && commit_a.is_branch && commit_a.mispredict)
				flush_count++;
			if (commit_b.valid && commit_b.is_branch && commit_b.mispredict)
				flush_count++;
		end
	end

	initial
	begin
		int mark;
		int mark2;
		int k;
		clock = 1'b0;
		reset = 1'b1;
		dispatch_thread = 1'b0;
		inst_a = '0;
		inst_b = '0;
		comp_a = '0;
		comp_b = '0;
		lcg_state = 32'h74320bd7;
		checking = 1'b0;
		exp_a = '0;
		exp_b = '0;
		exp_tag_a = '0;
		exp_tag_b = '0;
		exp_ready = 2'b11;
		disp_mode = 0;
		pair_only = 1'b0;
		comp_rate = 0;
		mis_en = 1'b0;
		failures = 0;
		mismatches = 0;
		commits_seen = 0;
		dual_seen = 0;
		flush_count = 0;
		post_flush_disp = 0;
		tests_run = 0;
		tests_failed = 0;
		test_start_errors = 0;
		clear_model();
		repeat (2) @(posedge clock);
		#5;
		reset = 1'b0;
		checking = 1'b1;

		if (ready !== 2'b11)
		begin
			print_mismatch($sformatf("ready %b after reset, expected 11", ready));
			failures++;
		end
		disp_mode = 1;
		pair_only = 1'b1;
		check_first_tags(1'b0);
		disp_mode = 2;
		check_first_tags(1'b1);
		finish_test("reset");

		// one thread, completions land out of order
		drain_queues();
		disp_mode = 1;
		pair_only = 1'b0;
		comp_rate = 3;
		mark = commits_seen;
		run_cycles(200);
		if (commits_seen - mark < 20)
			report_failure("fewer than 20 commits in the in-order test");
		finish_test("in_order");

		disp_mode = 3;
		comp_rate = 6;
		mark = dual_seen;
		run_cycles(300);
		if (dual_seen == mark)
			report_failure("no cycle committed from both threads");
		finish_test("two_threads");

		mis_en = 1'b1;
		comp_rate = 5;
		mark = flush_count;
		mark2 = post_flush_disp;
		run_cycles(400);
		if (flush_count == mark || post_flush_disp == mark2)
			report_failure("no mispredict flush followed by a dispatch was seen");
		finish_test("mispredict");

		// fill thread 1 with pairs, then let commits make room again
		drain_queues();
		disp_mode = 1;
		pair_only = 1'b1;
		comp_rate = 0;
		k = 0;
		while (ready[0] === 1'b1 && k < 20)
		begin
			step();
			k++;
		end
		if (ready[0] !== 1'b0)
			report_failure("timeout, the thread 1 ready bit did not fall while filling");
		disp_mode = 0;
		comp_rate = 8;
		k = 0;
		while (ready[0] !== 1'b1 && k < 40)
		begin
			step();
			k++;
		end
		if (ready[0] !== 1'b1)
			report_failure("timeout, the thread 1 ready bit did not rise after commits");
		drain_queues();
		finish_test("full_flag");

		checking = 1'b0;
		$display("tests %0d, failed %0d, errors %0d, commits %0d, flushes %0d",
			tests_run, tests_failed, failures + mismatches, commits_seen, flush_count);
		if (tests_failed == 0 && failures + mismatches == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

/* rob_top.sv */
// two-thread reorder buffer, ROB_DEPTH entries per thread
// tags come back in the dispatch cycle; dispatch only to a thread whose ready bit is high
// commit outputs are combinational from registered state
`timescale 1ns/1ps
`include "rob_macros.svh"

module rob_top (
	input	logic						clock,
	input	logic						reset,
	input	logic						dispatch_thread,
	input	rob_pkg::dispatch_inst_t	inst_a,
	input	rob_pkg::dispatch_inst_t	inst_b,
	input	rob_pkg::completion_t		comp_a,
	input	rob_pkg::completion_t		comp_b,
	output	rob_pkg::rob_tag_t			tag_a,
	output	rob_pkg::rob_tag_t			tag_b,
	output	logic [1:0]					ready,
	output	rob_pkg::commit_t			commit_a,
	output	rob_pkg::commit_t			commit_b
);
	import rob_pkg::*;

	rob_ptr_t [1:0]						head_ptr;
	rob_ptr_t [1:0]						tail_ptr;
	flush_t [1:0]						flush;
	logic [1:0][`ROB_DEPTH-1:0]			load_en_a;
	logic [1:0][`ROB_DEPTH-1:0]			load_en_b;
	logic [1:0][`ROB_DEPTH-1:0]			valid_vec;
	logic [1:0][`ROB_DEPTH-1:0]			release_vec;
	rob_entry_t [1:0][`ROB_DEPTH-1:0]	entries;

	dispatch_alloc dispatch_alloc_i (
		.clock				(clock),
		.reset				(reset),
		.dispatch_thread	(dispatch_thread),
		.inst_a				(inst_a),
		.inst_b				(inst_b),
		.head_ptr			(head_ptr),
		.flush				(flush),
		.tag_a				(tag_a),
		.tag_b				(tag_b),
		.ready				(ready),
		.tail_ptr			(tail_ptr),
		.load_en_a			(load_en_a),
		.load_en_b			(load_en_b)
	);

	// bank 0 holds thread 1, bank 1 holds thread 2
	for (genvar t = 0; t < 2; t++)
	begin : g_bank
		rob_thread_bank #(
			.thread_id	(t == 1)
		) rob_thread_bank_i (
			.clock			(clock),
			.reset			(reset),
			.load_en_a		(load_en_a[t]),
			.load_en_b		(load_en_b[t]),
			.inst_a			(inst_a),
			.inst_b			(inst_b),
			.comp_a			(comp_a),
			.comp_b			(comp_b),
			.release_vec	(release_vec[t]),
			.flush_all		(flush[t].valid),
			.entries		(entries[t]),
			.valid_vec		(valid_vec[t])
		);
	end

	commit_select commit_select_i (
		.clock			(clock),
		.reset			(reset),
		.entries		(entries),
		.valid_vec		(valid_vec),
		.tail_ptr		(tail_ptr),
		.commit_a		(commit_a),
		.commit_b		(commit_b),
		.release_vec	(release_vec),
		.flush			(flush),
		.head_ptr		(head_ptr)
	);

endmodule

/* commit_select.sv */
// in-order commit of up to two entries per cycle
// thread 1 has priority for slot a; slot b prefers the next entry of the same thread
// commit outputs are one-cycle pulses with no back-pressure
// a committed mispredicted branch flushes its thread back to the new head
`timescale 1ns/1ps
`include "rob_macros.svh"

module commit_select (
	input	logic										clock,
	input	logic										reset,
	input	rob_pkg::rob_entry_t [1:0][`ROB_DEPTH-1:0]	entries,
	input	logic [1:0][`ROB_DEPTH-1:0]					valid_vec,
	input	rob_pkg::rob_ptr_t [1:0]					tail_ptr,
	output	rob_pkg::commit_t							commit_a,
	output	rob_pkg::commit_t							commit_b,
	output	logic [1:0][`ROB_DEPTH-1:0]					release_vec,
	output	rob_pkg::flush_t [1:0]						flush,
	output	rob_pkg::rob_ptr_t [1:0]					head_ptr
);
	import rob_pkg::*;

	rob_idx_t [1:0]	head_idx;
	rob_idx_t [1:0]	next_idx;
	logic [1:0]		head_ok;
	logic [1:0]		next_ok;
	rob_ptr_t [1:0]	count;
	rob_ptr_t [1:0]	head_d;
	logic			a_valid;
	logic			a_thread;
	rob_idx_t		a_idx;
	rob_entry_t		a_entry;
	logic			a_mispredict;
	logic			b_valid;
	logic			b_thread;
	rob_idx_t		b_idx;
	rob_entry_t		b_entry;
	logic			b_mispredict;

	function automatic commit_t make_commit(logic valid, logic thread, rob_entry_t e);
		commit_t c;
		c = '0;
		c.arn_dest = arn_t'(`ZERO_REG);
		if (valid)
		begin
			c.valid = 1'b1;
			c.thread = thread;
			c.pc = e.pc;
			c.target_pc = e.target_pc;
			c.is_branch = e.is_branch;
			c.mispredict = e.mispredict;
			c.arn_dest = e.arn_dest;
			c.prn_dest = e.prn_dest;
			c.is_halt = e.is_halt;
		end
		return c;
	endfunction

	always_comb
	begin
		for (int t = 0; t < 2; t++)
		begin
			head_idx[t] = rob_idx_t'(head_ptr[t]);
			next_idx[t] = head_idx[t] + rob_idx_t'(1);
			head_ok[t] = valid_vec[t][head_idx[t]] && entries[t][head_idx[t]].done;
			next_ok[t] = valid_vec[t][next_idx[t]] && entries[t][next_idx[t]].done
				&& (head_ptr[t] + rob_ptr_t'(1) != tail_ptr[t]);
		end

		a_valid = head_ok[0] | head_ok[1];
		a_thread = ~head_ok[0];	// thread 1 first
		a_idx = head_idx[a_thread];
		a_entry = entries[a_thread][a_idx];
		a_mispredict = a_valid && a_entry.is_branch && a_entry.mispredict;

		// younger entry of a mispredicted branch never retires with it
		b_valid = 1'b0;
		b_thread = a_thread;
		b_idx = next_idx[a_thread];
		if (a_valid && next_ok[a_thread] && !a_mispredict)
			b_valid = 1'b1;
		else if (a_valid && !a_thread && head_ok[1])
		begin
			b_valid = 1'b1;
			b_thread = 1'b1;
			b_idx = head_idx[1];
		end
		b_entry = entries[b_thread][b_idx];
		b_mispredict = b_valid && b_entry.is_branch && b_entry.mispredict;

		release_vec = '0;
		count = '0;
		if (a_valid)
		begin
			release_vec[a_thread][a_idx] = 1'b1;
			count[a_thread] = count[a_thread] + rob_ptr_t'(1);
		end
		if (b_valid)
		begin
			release_vec[b_thread][b_idx] = 1'b1;
			count[b_thread] = count[b_thread] + rob_ptr_t'(1);
		end

		for (int t = 0; t < 2; t++)
		begin
			head_d[t] = head_ptr[t] + count[t];
			flush[t].valid = 1'b0;
			flush[t].new_tail = head_d[t];
		end
		if (a_mispredict)
			flush[a_thread].valid = 1'b1;
		if (b_mispredict)
			flush[b_thread].valid = 1'b1;
	end

	assign commit_a = make_commit(a_valid, a_thread, a_entry);
	assign commit_b = make_commit(b_valid, b_thread, b_entry);

	always_ff @(posedge clock)
	begin
		if (reset)
			head_ptr <= '0;
		else
			head_ptr <= head_d;
	end

	a_slot_order: assert property (@(posedge clock) disable iff (reset)
		commit_b.valid |-> commit_a.valid)
		else $error("commit slot b valid without slot a");

endmodule

/* rob_thread_bank.sv */
// entry storage for one thread
// completions whose tag thread differs from thread_id are ignored
// port a wins when both completion ports name the same entry
// a flush clears every valid bit of the bank in one cycle
`timescale 1ns/1ps
`include "rob_macros.svh"

module rob_thread_bank #(
	parameter logic thread_id = 1'b0
) (
	input	logic									clock,
	input	logic									reset,
	input	logic [`ROB_DEPTH-1:0]					load_en_a,
	input	logic [`ROB_DEPTH-1:0]					load_en_b,
	input	rob_pkg::dispatch_inst_t				inst_a,
	input	rob_pkg::dispatch_inst_t				inst_b,
	input	rob_pkg::completion_t					comp_a,
	input	rob_pkg::completion_t					comp_b,
	input	logic [`ROB_DEPTH-1:0]					release_vec,
	input	logic									flush_all,
	output	rob_pkg::rob_entry_t [`ROB_DEPTH-1:0]	entries,
	output	logic [`ROB_DEPTH-1:0]					valid_vec
);
	import rob_pkg::*;

	logic	own_a;
	logic	own_b;

	assign own_a = comp_a.valid && (comp_a.tag.thread == thread_id);
	assign own_b = comp_b.valid && (comp_b.tag.thread == thread_id);

	// new entry starts not done
	function automatic rob_entry_t fresh_entry(dispatch_inst_t inst);
		rob_entry_t e;
		e.pc = inst.pc;
		e.arn_dest = inst.arn_dest;
		e.prn_dest = inst.prn_dest;
		e.is_branch = inst.is_branch;
		e.is_halt = inst.is_halt;
		e.done = 1'b0;
		e.mispredict = 1'b0;
		e.target_pc = '0;
		return e;
	endfunction

	always_ff @(posedge clock)
	begin
		for (int i = 0; i < `ROB_DEPTH; i++)
		begin
			if (load_en_a[i])
				entries[i] <= fresh_entry(inst_a);
			else if (load_en_b[i])
				entries[i] <= fresh_entry(inst_b);
			else if (own_a && comp_a.tag.idx == rob_idx_t'(i))
			begin
				entries[i].done <= 1'b1;
				entries[i].mispredict <= comp_a.mispredict;
				entries[i].target_pc <= comp_a.target_pc;
			end
			else if (own_b && comp_b.tag.idx == rob_idx_t'(i))
			begin
				entries[i].done <= 1'b1;
				entries[i].mispredict <= comp_b.mispredict;
				entries[i].target_pc <= comp_b.target_pc;
			end
		end
	end

	// loads only hit free slots and releases only live ones, so the two never overlap
	always_ff @(posedge clock)
	begin
		if (reset || flush_all)
			valid_vec <= '0;
		else
			valid_vec <= (valid_vec & ~release_vec) | load_en_a | load_en_b;
	end

	// a functional unit must not report on an entry that was never dispatched or was flushed
	a_comp_a_live: assert property (@(posedge clock) disable iff (reset)
		own_a |-> valid_vec[comp_a.tag.idx])
		else $error("completion port a hits free entry %0d", comp_a.tag.idx);

	a_comp_b_live: assert property (@(posedge clock) disable iff (reset)
		own_b |-> valid_vec[comp_b.tag.idx])
		else $error("completion port b hits free entry %0d", comp_b.tag.idx);

endmodule

/* dispatch_alloc.sv */
// tail pointers and entry allocation for both threads
// a thread is ready while at least two entries are free
// a dispatch to a thread that is not ready, or in a cycle with any flush,
// is dropped and returns zero tags; inst_b is taken only with inst_a
`timescale 1ns/1ps
`include "rob_macros.svh"

module dispatch_alloc (
	input	logic								clock,
	input	logic								reset,
	input	logic								dispatch_thread,
	input	rob_pkg::dispatch_inst_t			inst_a,
	input	rob_pkg::dispatch_inst_t			inst_b,
	input	rob_pkg::rob_ptr_t [1:0]			head_ptr,
	input	rob_pkg::flush_t [1:0]				flush,
	output	rob_pkg::rob_tag_t					tag_a,
	output	rob_pkg::rob_tag_t					tag_b,
	output	logic [1:0]							ready,
	output	rob_pkg::rob_ptr_t [1:0]			tail_ptr,
	output	logic [1:0][`ROB_DEPTH-1:0]			load_en_a,
	output	logic [1:0][`ROB_DEPTH-1:0]			load_en_b
);
	import rob_pkg::*;

	rob_ptr_t [1:0]	used;
	rob_ptr_t [1:0]	tail_d;
	rob_ptr_t		advance;
	rob_idx_t		idx_a;
	rob_idx_t		idx_b;
	logic			flush_any;
	logic			take_a;
	logic			take_b;

	always_comb
	begin
		for (int t = 0; t < 2; t++)
		begin
			used[t] = tail_ptr[t] - head_ptr[t];	// 0 to ROB_DEPTH thanks to the wrap bit
			ready[t] = (used[t] <= rob_ptr_t'(`ROB_DEPTH - 2));
		end
	end

	assign flush_any = flush[0].valid | flush[1].valid;
	assign take_a = inst_a.valid & ready[dispatch_thread] & ~flush_any;
	assign take_b = take_a & inst_b.valid;
	assign idx_a = rob_idx_t'(tail_ptr[dispatch_thread]);
	assign idx_b = idx_a + rob_idx_t'(1);
	assign advance = rob_ptr_t'(take_a) + rob_ptr_t'(take_b);

	always_comb
	begin
		tag_a = '0;
		tag_b = '0;
		load_en_a = '0;
		load_en_b = '0;
		if (take_a)
		begin
			tag_a.thread = dispatch_thread;
			tag_a.idx = idx_a;
			load_en_a[dispatch_thread][idx_a] = 1'b1;
		end
		if (take_b)
		begin
			tag_b.thread = dispatch_thread;
			tag_b.idx = idx_b;
			load_en_b[dispatch_thread][idx_b] = 1'b1;
		end

		tail_d = tail_ptr;
		tail_d[dispatch_thread] = tail_ptr[dispatch_thread] + advance;
		for (int t = 0; t < 2; t++)
		begin
			if (flush[t].valid)
				tail_d[t] = flush[t].new_tail;	// drop everything younger than the branch
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			tail_ptr <= '0;
		else
			tail_ptr <= tail_d;
	end

	// ready depends on the head kept by the commit side
	a_dispatch_ready: assert property (@(posedge clock) disable iff (reset)
		(inst_a.valid && !flush_any) |-> ready[dispatch_thread])
		else $error("dispatch to thread bit %0d while it is not ready", dispatch_thread);

endmodule

/* rob_pkg.sv */
// types shared by the reorder buffer
// a thread bit of 0 names thread 1 and a bit of 1 names thread 2
`include "rob_macros.svh"

package rob_pkg;

	typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;
	typedef logic [$clog2(`ROB_DEPTH):0] rob_ptr_t;	// msb is the wrap bit
	typedef logic [`PC_WIDTH-1:0] pc_t;
	typedef logic [$clog2(`ARCH_REGS)-1:0] arn_t;
	typedef logic [$clog2(`PRF_DEPTH)-1:0] prn_t;

	// names one entry across both queues
	typedef struct packed {
		logic		thread;
		rob_idx_t	idx;
	} rob_tag_t;

	typedef struct packed {
		logic	valid;
		pc_t	pc;
		arn_t	arn_dest;
		prn_t	prn_dest;
		logic	is_branch;
		logic	is_halt;
	} dispatch_inst_t;

	typedef struct packed {
		pc_t	pc;
		arn_t	arn_dest;
		prn_t	prn_dest;
		logic	is_branch;
		logic	is_halt;
		logic	done;
		logic	mispredict;
		pc_t	target_pc;
	} rob_entry_t;

	// report from one functional unit
	typedef struct packed {
		logic		valid;
		rob_tag_t	tag;
		logic		mispredict;
		pc_t		target_pc;
	} completion_t;

	typedef struct packed {
		logic	valid;
		logic	thread;
		pc_t	pc;
		pc_t	target_pc;
		logic	is_branch;
		logic	mispredict;
		arn_t	arn_dest;
		prn_t	prn_dest;
		logic	is_halt;
	} commit_t;

	typedef struct packed {
		logic		valid;
		rob_ptr_t	new_tail;	// head after this cycle's commits
	} flush_t;

endpackage

/* rob_macros.svh */
// sizes shared by the reorder buffer RTL
// ROB_DEPTH must be a power of two since the pointers wrap by truncation
// register number widths follow from PRF_DEPTH and ARCH_REGS
`ifndef ROB_MACROS_SVH
`define ROB_MACROS_SVH

// entries per thread
`define ROB_DEPTH	16

// physical register file
`define PRF_DEPTH	64

// architectural registers
`define ARCH_REGS	32

`define PC_WIDTH	64

// arn driven on an idle commit slot so that the write is discarded downstream
`define ZERO_REG	31

`endif
